// ==== sim/aes_golden.hex ====
// one vector per line: key, plaintext, expected ciphertext, each 128 bits.
// vector 0 is FIPS-197 appendix B, vector 1 is appendix C.1, then SP 800-38A ECB
// and two known-answer vectors with an all-zero key.
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e

// ==== aes_encrypt_top.f ====
rtl/aes_pkg.sv
rtl/aes_block_loader.sv
rtl/aes_key_schedule.sv
rtl/aes_round_engine.sv
rtl/aes_ciphertext_unloader.sv
rtl/aes_encrypt_top.sv
sim/tb_aes_encrypt.sv

// ==== Makefile ====
# Verilator flow for the AES-128 encryption core.
TB  = tb_aes_encrypt
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module aes_encrypt_top -f aes_encrypt_top.f

sim:
	verilator --binary --timing --assert --top-module $(TB) -f aes_encrypt_top.f \
		--Mdir obj_dir -o $(TB)
	./obj_dir/$(TB) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_aes_encrypt.sv ====
`timescale 1ns/1ps

module tb_aes_encrypt
    import aes_pkg::*;
();

    localparam int IO_WIDTH    = 64;
    localparam int WORDS       = AES_BLOCK_BITS / IO_WIDTH; // words per block on each side.
    localparam int NUM_VEC     = 8;                         // vectors in the golden file.
    localparam int NUM_BLOCKS  = 2 * NUM_VEC + 2;           // two passes and the key change pair.
    localparam int CYCLE_LIMIT = NUM_BLOCKS * 40 + 100;
    localparam int LATENCY     = 13; // from the edge that samples pt_last to the first word.

    logic                      clk;
    logic                      resetn;
    logic [IO_WIDTH-1:0]       pt_data;
    logic                      pt_valid;
    logic                      pt_last;
    logic                      key_load;
    logic [AES_BLOCK_BITS-1:0] key_in;
    logic [IO_WIDTH-1:0]       ct_word;
    logic                      ct_valid;
    logic                      ct_last;
    logic                      busy;

    logic [AES_BLOCK_BITS-1:0] golden [0:3*NUM_VEC-1]; // key, plaintext, ciphertext per vector.
    logic [AES_BLOCK_BITS-1:0] acc;                    // ciphertext words gathered so far.
    aes_state_t exp_ct[$];    // expected results in output order.
    string      exp_name[$];
    int         exp_edge[$];  // cycle of the edge that sampled pt_last.
    int         exp_lat[$];
    int         cyc      = 0;
    int         sent_cnt = 0;
    int         done_cnt = 0;
    int         word_idx = 0;
    int         edge_a;
    int         edge_b;

    aes_encrypt_top #(
        .IO_WIDTH (IO_WIDTH)
    ) i_dut (
        .clk      (clk),
        .resetn   (resetn),
        .pt_data  (pt_data),
        .pt_valid (pt_valid),
        .pt_last  (pt_last),
        .key_load (key_load),
        .key_in   (key_in),
        .ct_word  (ct_word),
        .ct_valid (ct_valid),
        .ct_last  (ct_last),
        .busy     (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_block(input string name, input aes_state_t expected,
                                 input aes_state_t actual);
        if (actual !== expected)
            report_error($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic compare_latency(input string name, input int expected, input int actual);
        if (actual != expected)
            report_error($sformatf("FAILED %s latency: expected %0d, actual %0d",
                                   name, expected, actual));
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            report_error($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
    endtask

    // the run may not go on forever if the DUT stops producing words.
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc > CYCLE_LIMIT)
            report_error($sformatf("timeout after %0d cycles, %0d of %0d blocks came out",
                                   cyc, done_cnt, sent_cnt));
    end

    // output words are sampled on the falling edge where they are stable.
    always @(negedge clk)
    begin
        if (resetn && ct_valid)
        begin
            if (exp_ct.size() == 0)
                report_error("a ciphertext word came out with no block outstanding");
            if (word_idx == 0)
            begin
                compare_latency(exp_name[0], exp_lat[0], cyc - exp_edge[0]);
                void'(exp_lat.pop_front());
                void'(exp_edge.pop_front());
            end
            compare_flag($sformatf("%s ct_last on word %0d", exp_name[0], word_idx),
                         word_idx == WORDS - 1, ct_last);
            acc = {acc[AES_BLOCK_BITS-IO_WIDTH-1:0], ct_word}; // first word ends on top.
            if (word_idx == WORDS - 1)
            begin
                compare_block(exp_name.pop_front(), exp_ct.pop_front(), acc);
                word_idx = 0;
                done_cnt = done_cnt + 1;
            end
            else
                word_idx = word_idx + 1;
        end
    end

    task automatic load_key(input logic [AES_BLOCK_BITS-1:0] key);
        @(negedge clk);
        key_in   = key;
        key_load = 1'b1;
        @(negedge clk);
        key_load = 1'b0;
    endtask

    // sends one block, top word first, with up to max_gap idle cycles before each word.
    task automatic send_block(input logic [AES_BLOCK_BITS-1:0] pt, input int max_gap,
                              output int edge0);
        logic [AES_BLOCK_BITS-1:0] rest;
        rest = pt;
        for (int w = 0; w < WORDS; w++)
        begin
            if (max_gap > 0)
                repeat ($urandom % (max_gap + 1)) @(negedge clk);
            @(negedge clk);
            pt_data  = rest[AES_BLOCK_BITS-1 -: IO_WIDTH];
            pt_valid = 1'b1;
            pt_last  = (w == WORDS - 1);
            edge0    = cyc + 1; // the next rising edge samples this word.
            rest     = rest << IO_WIDTH;
            @(negedge clk);
            pt_valid = 1'b0;
            pt_last  = 1'b0;
        end
    endtask

    task automatic expect_block(input string name, input aes_state_t ct, input int edge0,
                                input int lat);
        exp_name.push_back(name);
        exp_ct.push_back(ct);
        exp_edge.push_back(edge0);
        exp_lat.push_back(lat);
        sent_cnt = sent_cnt + 1;
    endtask

    task automatic wait_done();
        while (done_cnt < sent_cnt)
            @(posedge clk); // the monitor counts on the falling edge.
    endtask

    task automatic run_vector(input int v, input int max_gap, input string tag);
        int edge0;
        load_key(golden[3*v]);
        send_block(golden[3*v+1], max_gap, edge0);
        expect_block($sformatf("%s vector %0d", tag, v), golden[3*v+2], edge0, LATENCY);
        wait_done();
    endtask

    initial
    begin
        resetn   = 1'b0;
        pt_data  = '0;
        pt_valid = 1'b0;
        pt_last  = 1'b0;
        key_load = 1'b0;
        key_in   = '0;
        acc      = '0;
        void'($urandom(32'h7efe));
        $readmemh("sim/aes_golden.hex", golden);
        if ($isunknown(golden[3*NUM_VEC-1]) || golden[3*NUM_VEC-1] == '0)
            report_error("the golden file is missing or holds too few vectors");
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        // nothing may start before the first block arrives.
        repeat (3)
        begin
            @(negedge clk);
            compare_flag("busy after reset", 1'b0, busy);
            compare_flag("ct_valid after reset", 1'b0, ct_valid);
        end
        for (int v = 0; v < NUM_VEC; v++)
            run_vector(v, 0, "fixed gap");
        for (int v = 0; v < NUM_VEC; v++)
            run_vector(v, 3, "random gap");
        // block a runs with the key of vector 0, block b queues behind it with vector 1's key.
        load_key(golden[0]);
        send_block(golden[1], 0, edge_a);
        expect_block("key change block a", golden[2], edge_a, LATENCY);
        while (!busy)
            @(negedge clk);
        load_key(golden[3]);
        send_block(golden[4], 0, edge_b);
        compare_flag("busy while the second block is loaded", 1'b1, busy);
        // block b is taken the cycle after a finishes and needs the same twelve edges again.
        expect_block("key change block b", golden[5], edge_b,
                     edge_a + LATENCY + AES_ROUNDS + 2 - edge_b);
        wait_done();
        // a stray word in these cycles is caught by the monitor.
        repeat (4) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== rtl/aes_encrypt_top.sv ====
`timescale 1ns/1ps

module aes_encrypt_top
    import aes_pkg::*;
#(
    parameter int IO_WIDTH = 64 // 64 gives two words per block, 32 gives four.
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic [IO_WIDTH-1:0]       pt_data,
    input  logic                      pt_valid,
    input  logic                      pt_last,
    input  logic                      key_load,
    input  logic [AES_BLOCK_BITS-1:0] key_in,
    output logic [IO_WIDTH-1:0]       ct_word,
    output logic                      ct_valid,
    output logic                      ct_last,
    output logic                      busy
);

    logic                      blk_ready; // loader holds a full block.
    logic                      blk_take;
    aes_state_t                blk_data;
    logic                      ks_start;
    logic                      ks_step;
    logic [AES_BLOCK_BITS-1:0] round_key;
    logic                      ct_ready;  // one-cycle pulse per finished block.
    aes_state_t                ct_data;

    aes_block_loader #(
        .IO_WIDTH (IO_WIDTH)
    ) i_loader (
        .clk       (clk),
        .resetn    (resetn),
        .pt_data   (pt_data),
        .pt_valid  (pt_valid),
        .pt_last   (pt_last),
        .blk_take  (blk_take),
        .blk_ready (blk_ready),
        .blk_data  (blk_data)
    );

    aes_key_schedule i_key_schedule (
        .clk       (clk),
        .resetn    (resetn),
        .key_load  (key_load),
        .key_in    (key_in),
        .ks_start  (ks_start),
        .ks_step   (ks_step),
        .round_key (round_key)
    );

    aes_round_engine i_engine (
        .clk       (clk),
        .resetn    (resetn),
        .blk_ready (blk_ready),
        .blk_data  (blk_data),
        .round_key (round_key),
        .blk_take  (blk_take),
        .ks_start  (ks_start),
        .ks_step   (ks_step),
        .busy      (busy),
        .ct_ready  (ct_ready),
        .ct_data   (ct_data)
    );

    aes_ciphertext_unloader #(
        .IO_WIDTH (IO_WIDTH)
    ) i_unloader (
        .clk      (clk),
        .resetn   (resetn),
        .ct_ready (ct_ready),
        .ct_data  (ct_data),
        .ct_word  (ct_word),
        .ct_valid (ct_valid),
        .ct_last  (ct_last)
    );

endmodule

// ==== rtl/aes_ciphertext_unloader.sv ====
`timescale 1ns/1ps

module aes_ciphertext_unloader
    import aes_pkg::*;
#(
    parameter int IO_WIDTH = 64
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                ct_ready,
    input  aes_state_t          ct_data,
    output logic [IO_WIDTH-1:0] ct_word,
    output logic                ct_valid,
    output logic                ct_last
);

    localparam int WORDS = AES_BLOCK_BITS / IO_WIDTH;
    localparam int CNT_W = $clog2(WORDS);

    logic [AES_BLOCK_BITS-1:0] shift_q; // the current word is always on top.
    logic [CNT_W-1:0]          left_q;  // words still to show after the current one.

    assign ct_word = shift_q[AES_BLOCK_BITS-1 -: IO_WIDTH];

    always_ff @(posedge clk)
    begin
        if (ct_ready)
            shift_q <= ct_data;
        else if (left_q != '0)
            shift_q <= shift_q << IO_WIDTH; // bring the next word to the top.
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ct_valid <= 1'b0;
            ct_last  <= 1'b0;
            left_q   <= '0;
        end
        else if (ct_ready)
        begin
            ct_valid <= 1'b1;
            ct_last  <= (WORDS == 1);
            left_q   <= CNT_W'(WORDS - 1);
        end
        else if (left_q != '0)
        begin
            ct_valid <= 1'b1;
            ct_last  <= (left_q == CNT_W'(1)); // the word now coming out is the final one.
            left_q   <= left_q - 1'b1;
        end
        else
        begin
            ct_valid <= 1'b0;
            ct_last  <= 1'b0;
        end
    end

    // with no back-pressure a new block must not overrun the previous one.
    a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
        ct_ready |-> (left_q == '0));

endmodule

// ==== rtl/aes_round_engine.sv ====
`timescale 1ns/1ps

module aes_round_engine
    import aes_pkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      blk_ready,
    input  aes_state_t                blk_data,
    input  logic [AES_BLOCK_BITS-1:0] round_key,
    output logic                      blk_take,
    output logic                      ks_start,
    output logic                      ks_step,
    output logic                      busy,
    output logic                      ct_ready,
    output aes_state_t                ct_data
);

    logic       busy_q;  // a block is being worked on.
    logic [3:0] rnd_q;   // 0 means whitening, 1 to 10 are the rounds.
    logic       last_rnd;
    aes_state_t state_q; // the cipher state between rounds.
    aes_state_t shifted; // after SubBytes and ShiftRows.
    aes_state_t mixed;   // after MixColumns.
    aes_state_t round_out;

    // an idle engine takes a waiting block at once, and the key schedule
    // loads the master key on the same edge.
    assign blk_take = blk_ready && !busy_q;
    assign ks_start = blk_take;

    // the key for round n+1 is prepared while round n runs.
    // after the tenth key no more expansion is needed.
    assign last_rnd = (rnd_q == 4'(AES_ROUNDS));
    assign ks_step  = busy_q && !last_rnd;

    assign busy    = busy_q;
    assign ct_data = state_q; // holds the ciphertext in the cycle of ct_ready.

    always_comb
    begin
        // byte r of column c comes from column c+r of the same row.
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                shifted.bytes[4*c + r] = sbox(state_q.bytes[4*((c + r) % 4) + r]);
        end
        for (int c = 0; c < 4; c++)
            mixed.cols[c] = mix_column(shifted.cols[c]);
        // the final round has no MixColumns.
        round_out = last_rnd ? shifted : mixed;
    end

    always_ff @(posedge clk)
    begin
        if (blk_take)
            state_q <= blk_data;
        else if (busy_q)
        begin
            if (rnd_q == 4'd0)
                state_q <= state_q ^ round_key;   // initial key whitening with the master key.
            else
                state_q <= round_out ^ round_key; // AddRoundKey closes every round.
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy_q   <= 1'b0;
            rnd_q    <= 4'd0;
            ct_ready <= 1'b0;
        end
        else
        begin
            ct_ready <= 1'b0;
            if (blk_take)
            begin
                busy_q <= 1'b1;
                rnd_q  <= 4'd0;
            end
            else if (busy_q)
            begin
                if (last_rnd)
                begin
                    busy_q   <= 1'b0;   // the next block may be taken in the following cycle.
                    rnd_q    <= 4'd0;
                    ct_ready <= 1'b1;
                end
                else
                    rnd_q <= rnd_q + 4'd1;
            end
        end
    end

    // the counter stays within the round range for the whole run of a block.
    a_round_bound: assert property (@(posedge clk) disable iff (!resetn)
        busy_q |-> (rnd_q <= 4'(AES_ROUNDS)));

endmodule

// ==== rtl/aes_key_schedule.sv ====
`timescale 1ns/1ps

module aes_key_schedule
    import aes_pkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      key_load,
    input  logic [AES_BLOCK_BITS-1:0] key_in,
    input  logic                      ks_start,
    input  logic                      ks_step,
    output logic [AES_BLOCK_BITS-1:0] round_key
);

    logic [AES_BLOCK_BITS-1:0] master_q; // key used by every block started from now on.
    logic [7:0]                rcon_q;   // round constant for the next expansion step.
    logic [0:3][31:0]          key_words;
    logic [0:3][31:0]          next_words;
    logic [31:0]               rot_word;
    logic [31:0]               temp_word;

    assign key_words = round_key; // word 0 is the top 32 bits.

    always_comb
    begin
        rot_word = {key_words[3][23:0], key_words[3][31:24]}; // RotWord of the last word.
        for (int i = 0; i < 4; i++)
            temp_word[8*i +: 8] = sbox(rot_word[8*i +: 8]); // SubWord, byte by byte.
        temp_word[31:24] = temp_word[31:24] ^ rcon_q;         // rcon only touches the top byte.
        // each new word is the old one xor the new word before it.
        next_words[0] = key_words[0] ^ temp_word;
        next_words[1] = key_words[1] ^ next_words[0];
        next_words[2] = key_words[2] ^ next_words[1];
        next_words[3] = key_words[3] ^ next_words[2];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            master_q <= '0;
            rcon_q   <= 8'h01;
        end
        else
        begin
            if (key_load)
                master_q <= key_in; // a running block keeps its own copy in round_key.
            if (ks_start)
                rcon_q <= 8'h01;
            else if (ks_step)
                rcon_q <= xtime(rcon_q); // 01, 02, 04 ... 80, 1b, 36.
        end
    end

    always_ff @(posedge clk)
    begin
        if (ks_start)
            round_key <= master_q;
        else if (ks_step)
            round_key <= next_words;
    end

    a_start_step_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(ks_start && ks_step));

endmodule

// ==== rtl/aes_block_loader.sv ====
`timescale 1ns/1ps

module aes_block_loader
    import aes_pkg::*;
#(
    parameter int IO_WIDTH = 64
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic [IO_WIDTH-1:0] pt_data,
    input  logic                pt_valid,
    input  logic                pt_last,
    input  logic                blk_take,
    output logic                blk_ready,
    output aes_state_t          blk_data
);

    localparam int WORDS = AES_BLOCK_BITS / IO_WIDTH; // words per block.
    localparam int CNT_W = $clog2(WORDS);

    logic [CNT_W-1:0]          cnt_q;   // position of the next word within the block.
    logic [AES_BLOCK_BITS-1:0] shift_q; // block under assembly.

    assign blk_data = shift_q;

    // words enter at the bottom and move up, so the first word ends up on top.
    always_ff @(posedge clk)
    begin
        if (pt_valid && !blk_ready)
            shift_q <= {shift_q[AES_BLOCK_BITS-IO_WIDTH-1:0], pt_data};
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            blk_ready <= 1'b0;
            cnt_q     <= '0;
        end
        else if (blk_ready)
        begin
            if (blk_take)
                blk_ready <= 1'b0; // the engine has copied the block.
        end
        else if (pt_valid)
        begin
            if (pt_last)
            begin
                blk_ready <= 1'b1;
                cnt_q     <= '0;
            end
            else
                cnt_q <= cnt_q + 1'b1;
        end
    end

    // a block is complete only when its last word lands in the last slot.
    a_last_position: assert property (@(posedge clk) disable iff (!resetn)
        (pt_valid && pt_last && !blk_ready) |-> (cnt_q == CNT_W'(WORDS - 1)));

    // the engine must never take a block that is not there.
    a_take_when_ready: assert property (@(posedge clk) disable iff (!resetn)
        blk_take |-> blk_ready);

endmodule

// ==== rtl/aes_pkg.sv ====
package aes_pkg;

    localparam int AES_ROUNDS     = 10;  // aes-128 runs ten full rounds after whitening.
    localparam int AES_BLOCK_BITS = 128; // block and key size in bits.

    // the cipher state seen two ways. byte 0 sits in the top eight bits, so the
    // sixteen bytes run down the columns exactly as FIPS-197 numbers them.
    typedef union packed {
        logic [0:15][7:0] bytes; // used by SubBytes and ShiftRows.
        logic [0:3][31:0] cols;  // used by MixColumns, column 0 on top.
    } aes_state_t;

    // forward s-box as sixteen rows of sixteen entries with entry 0 first.
    localparam logic [0:255][7:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // substitution of one byte through the table above.
    function automatic logic [7:0] sbox(input logic [7:0] b);
        return SBOX_TABLE[b];
    endfunction

    // multiply by x in GF(2^8); the carry out of bit 7 folds back as 8'h1b.
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // MixColumns on one column whose top byte is row 0.
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        // each row is 2*a(r) ^ 3*a(r+1) ^ a(r+2) ^ a(r+3), where 3*a = xtime(a) ^ a.
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

endpackage
